// ==== build.f ====
source/reflet_pkg.sv
source/reflet_counter.sv
source/reflet_timer.sv
source/reflet_interrupt_ctrl.sv
source/reflet_timer_subsystem.sv
dv/reflet_timer_checker.sv
dv/reflet_timer_tb.sv

// ==== dv/reflet_timer_checker.sv ====
module reflet_timer_checker (
    input  logic                              clk,
    input  logic                              enable,
    input  logic [reflet_pkg::addr_width-1:0] addr,
    input  logic                              write_en,
    input  logic [reflet_pkg::data_width-1:0] data_out,
    input  logic                              irq,
    input  logic                              chk_read,
    input  logic [reflet_pkg::data_width-1:0] exp_data,
    input  logic                              chk_irq,
    input  logic                              exp_irq,
    input  logic                              watch_low,
    input  logic                              chk_latency,
    input  logic [15:0]                       exp_latency,
    input  logic                              ref_sel,
    input  logic                              timeout_flag,
    output int unsigned                       value_errors,
    output int unsigned                       timeout_errors
);

    timeunit 1ns;
    timeprecision 100ps;

    import reflet_pkg::*;

    int unsigned cycle      = 0;
    int unsigned last_write = 0; // edge that took the latest bus write.
    int unsigned last_rise  = 0;
    int unsigned prev_rise  = 0;
    int unsigned latency    = 0;
    logic        irq_before = 1'b0;

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
    end

    // ########################################
    // edge numbering
    // ########################################

    // edge n leaves cycle at n, so the negedge after it also sees n.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (enable && write_en) begin
            last_write = cycle;
        end
    end

    // ########################################
    // comparisons, sampled mid cycle
    // ########################################

    always @(negedge clk) begin
        if (irq === 1'b1 && irq_before !== 1'b1) begin
            prev_rise = last_rise;
            last_rise = cycle; // irq went high after this edge.
        end
        irq_before = irq;

        if (chk_read && data_out !== exp_data) begin
            $display("** Error at %0t: data_out expected 0x%02h, got 0x%02h (addr 0x%04h)",
                     $time, exp_data, data_out, addr);
            value_errors++;
        end
        if (chk_irq && irq !== exp_irq) begin
            $display("** Error at %0t: irq expected %0b, got %0b", $time, exp_irq, irq);
            value_errors++;
        end
        if (watch_low && irq !== 1'b0) begin
            $display("** Error at %0t: irq expected 0, got %0b", $time, irq);
            value_errors++;
        end

        if (chk_latency) begin
            // the reference is either the last write or the rise before this one.
            latency = ref_sel ? last_rise - prev_rise : last_rise - last_write;
            if (latency != 32'(exp_latency)) begin
                $display("** Error at %0t: irq latency expected %0d, got %0d",
                         $time, exp_latency, latency);
                value_errors++;
            end
        end
        if (timeout_flag) begin
            $display("timeout at %0t: irq did not rise within %0d cycles", $time, exp_latency);
            timeout_errors++;
        end
    end

endmodule

// ==== dv/reflet_timer_tb.sv ====
module reflet_timer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import reflet_pkg::*;

    typedef enum logic [2:0] {
        op_write, op_read, op_irq_after, op_no_irq_for, op_clear_pending, op_irq_level
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  data;   // write data, expected read data, or a flag.
        logic [15:0] cycles;
    } row_t;

    localparam logic [addr_width-1:0] t0_pre1   = timer0_base + 16'(reg_pre1);
    localparam logic [addr_width-1:0] t0_pre2   = timer0_base + 16'(reg_pre2);
    localparam logic [addr_width-1:0] t0_arr    = timer0_base + 16'(reg_arr);
    localparam logic [addr_width-1:0] t1_pre1   = timer1_base + 16'(reg_pre1);
    localparam logic [addr_width-1:0] t1_pre2   = timer1_base + 16'(reg_pre2);
    localparam logic [addr_width-1:0] t1_arr    = timer1_base + 16'(reg_arr);
    localparam logic [addr_width-1:0] pend_addr = intc_base + 16'(reg_pending);
    localparam logic [addr_width-1:0] mask_addr = intc_base + 16'(reg_mask);
    localparam logic [7:0]            irq_bits  = 8'((1 << num_irq) - 1);
    localparam logic [7:0]            from_write = 8'd0;
    localparam logic [7:0]            from_rise  = 8'd1;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  enable;
    logic [addr_width-1:0] addr;
    logic                  write_en;
    logic [data_width-1:0] data_in;
    logic [data_width-1:0] data_out;
    logic                  irq;

    logic                  chk_read;
    logic [data_width-1:0] exp_data;
    logic                  chk_irq;
    logic                  exp_irq;
    logic                  watch_low;
    logic                  chk_latency;
    logic [15:0]           exp_latency;
    logic                  ref_sel;
    logic                  timeout_flag;
    int unsigned           value_errors;
    int unsigned           timeout_errors;
    row_t                  rows[$];

    always #10 clk = ~clk;

    reflet_timer_subsystem reflet_timer_subsystem_i (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .irq      (irq)
    );

    reflet_timer_checker reflet_timer_checker_i (
        .clk            (clk),
        .enable         (enable),
        .addr           (addr),
        .write_en       (write_en),
        .data_out       (data_out),
        .irq            (irq),
        .chk_read       (chk_read),
        .exp_data       (exp_data),
        .chk_irq        (chk_irq),
        .exp_irq        (exp_irq),
        .watch_low      (watch_low),
        .chk_latency    (chk_latency),
        .exp_latency    (exp_latency),
        .ref_sel        (ref_sel),
        .timeout_flag   (timeout_flag),
        .value_errors   (value_errors),
        .timeout_errors (timeout_errors)
    );

    // ########################################
    // row helpers
    // ########################################

    // cycles from one interrupt to the next.
    function automatic int unsigned period(input int unsigned pre1, pre2, arr);
        return (pre1 + 1) * (pre2 + 1) * arr;
    endfunction

    function automatic void add_row(input op_e op, input logic [15:0] a,
                                    input logic [7:0] d, input int unsigned n);
        row_t row;
        row.op     = op;
        row.addr   = a;
        row.data   = d;
        row.cycles = 16'(n);
        rows.push_back(row);
    endfunction

    function automatic void add_random_access(input logic [15:0] a);
        logic [7:0] value;
        value = 8'($urandom);
        add_row(op_write, a, value, 0);
        add_row(op_read, a, value, 0);
    endfunction

    task automatic drive_idle();
        enable       <= 1'b0;
        write_en     <= 1'b0;
        addr         <= '0;
        data_in      <= '0;
        chk_read     <= 1'b0;
        chk_irq      <= 1'b0;
        watch_low    <= 1'b0;
        chk_latency  <= 1'b0;
        timeout_flag <= 1'b0;
    endtask

    // each task starts on a rising edge and returns on a later one.
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        drive_idle();
        enable   <= 1'b1;
        write_en <= 1'b1;
        addr     <= a;
        data_in  <= d;
        @(posedge clk);
    endtask

    task automatic bus_read_check(input logic [15:0] a, input logic [7:0] d);
        drive_idle();
        enable   <= 1'b1;
        addr     <= a;
        chk_read <= 1'b1;
        exp_data <= d;
        @(posedge clk);
    endtask

    task automatic check_irq_level(input logic level);
        drive_idle();
        chk_irq <= 1'b1;
        exp_irq <= level;
        @(posedge clk);
    endtask

    task automatic watch_irq_low(input logic [15:0] cycles);
        drive_idle();
        watch_low <= 1'b1;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic wait_irq_rise(input logic [15:0] cycles, input logic prev_rise_ref);
        int unsigned waited;
        int unsigned limit;
        logic        risen;
        waited = 0;
        limit  = 32'(cycles) + 32;
        risen  = 1'b0;
        drive_idle();
        do begin
            @(negedge clk);
            waited++;
            risen = irq;
        end while (!risen && waited < limit);
        @(posedge clk);
        if (risen) begin
            chk_latency <= 1'b1;
            exp_latency <= cycles;
            ref_sel     <= prev_rise_ref;
        end else begin
            timeout_flag <= 1'b1;
            exp_latency  <= 16'(waited);
        end
        @(posedge clk);
    endtask

    task automatic apply_row(input row_t row);
        case (row.op)
            op_write:         bus_write(row.addr, row.data);
            op_read:          bus_read_check(row.addr, row.data);
            op_irq_after:     wait_irq_rise(row.cycles, row.data[0]);
            op_no_irq_for:    watch_irq_low(row.cycles);
            op_clear_pending: bus_write(pend_addr, row.data);
            op_irq_level:     check_irq_level(row.data[0]);
            default:          drive_idle();
        endcase
    endtask

    // ########################################
    // stimulus table
    // ########################################

    task automatic build_table();
        logic [7:0] value;
        for (int i = 0; i < 3 * block_span; i++) begin
            add_row(op_read, timer0_base + 16'(i), 8'h00, 0); // every byte reads zero after reset.
        end
        add_row(op_irq_level, '0, 8'd0, 0);
        add_random_access(t0_pre1);
        add_random_access(t0_pre2);
        add_random_access(t0_arr);
        add_random_access(t1_pre1);
        add_random_access(t1_pre2);
        add_random_access(t1_arr);
        value = 8'($urandom);
        add_row(op_write, mask_addr, value, 0);
        add_row(op_read, mask_addr, value & irq_bits, 0);
        add_row(op_read, timer0_base + 16'd3, 8'h00, 0);
        add_row(op_read, timer1_base + 16'd3, 8'h00, 0);
        add_row(op_read, intc_base + 16'd3, 8'h00, 0);
        add_row(op_read, 16'hFF0F, 8'h00, 0);
        add_row(op_read, 16'hFF1C, 8'h00, 0);
        add_row(op_read, 16'h0000, 8'h00, 0);
        // stop both timers and drop whatever the random setup left pending.
        add_row(op_write, mask_addr, 8'h00, 0);
        add_row(op_write, t0_arr, 8'd0, 0);
        add_row(op_write, t1_arr, 8'd0, 0);
        add_row(op_clear_pending, '0, 8'hFF, 0);
        add_row(op_read, pend_addr, 8'h00, 0);
        add_row(op_irq_level, '0, 8'd0, 0);
        // timer0 alone, arr written last.
        add_row(op_write, t0_pre1, 8'd2, 0);
        add_row(op_write, t0_pre2, 8'd1, 0);
        add_row(op_write, mask_addr, 8'h01, 0);
        add_row(op_write, t0_arr, 8'd3, 0);
        add_row(op_irq_after, '0, from_write, period(2, 1, 3));
        add_row(op_clear_pending, '0, 8'h01, 0);
        add_row(op_irq_level, '0, 8'd0, 0);
        add_row(op_irq_after, '0, from_rise, period(2, 1, 3));
        // invalid settings keep the chain at zero.
        add_row(op_write, t0_arr, 8'd0, 0);
        add_row(op_clear_pending, '0, 8'h01, 0);
        // a zero reload holds the chain instead of wrapping the full reload counter.
        add_row(op_no_irq_for, '0, 8'd0, period(2, 1, 1 << count_width) + 16);
        add_row(op_read, pend_addr, 8'h00, 0);
        add_row(op_write, t0_pre1, 8'd255, 0);
        add_row(op_write, t0_pre2, 8'd0, 0);
        add_row(op_write, t0_arr, 8'd1, 0);
        add_row(op_no_irq_for, '0, 8'd0, period(255, 0, 1) + 16);
        add_row(op_read, pend_addr, 8'h00, 0);
        add_row(op_write, t0_pre2, 8'd255, 0);
        add_row(op_write, t0_pre1, 8'd0, 0);
        add_row(op_no_irq_for, '0, 8'd0, period(0, 255, 1) + 16);
        add_row(op_read, pend_addr, 8'h00, 0);
        // timer1 runs masked, then gets unmasked.
        add_row(op_write, mask_addr, 8'h00, 0);
        add_row(op_write, t0_arr, 8'd0, 0);
        add_row(op_clear_pending, '0, 8'h03, 0);
        add_row(op_write, t1_pre1, 8'd1, 0);
        add_row(op_write, t1_pre2, 8'd2, 0);
        add_row(op_write, t1_arr, 8'd2, 0);
        add_row(op_no_irq_for, '0, 8'd0, period(1, 2, 2) + 8);
        add_row(op_read, pend_addr, 8'h02, 0);
        add_row(op_write, mask_addr, 8'h02, 0);
        add_row(op_irq_after, '0, from_write, 0);
        // both sources pending, cleared one at a time.
        add_row(op_write, mask_addr, 8'h00, 0);
        add_row(op_write, t0_pre1, 8'd2, 0);
        add_row(op_write, t0_pre2, 8'd1, 0);
        add_row(op_write, t0_arr, 8'd3, 0);
        add_row(op_no_irq_for, '0, 8'd0, period(2, 1, 3) + 8);
        add_row(op_read, pend_addr, 8'h03, 0);
        add_row(op_write, t0_arr, 8'd0, 0);
        add_row(op_write, t1_arr, 8'd0, 0);
        add_row(op_write, mask_addr, 8'h03, 0);
        add_row(op_irq_after, '0, from_write, 0);
        add_row(op_clear_pending, '0, 8'h01, 0);
        add_row(op_irq_level, '0, 8'd1, 0);
        add_row(op_read, pend_addr, 8'h02, 0);
        add_row(op_clear_pending, '0, 8'h02, 0);
        add_row(op_irq_level, '0, 8'd0, 0);
        add_row(op_read, pend_addr, 8'h00, 0);
    endtask

    initial begin
        void'($urandom(32'he0df));
        reset <= 1'b1;
        drive_idle();
        exp_data    <= '0;
        exp_irq     <= 1'b0;
        exp_latency <= '0;
        ref_sel     <= 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        drive_idle();
        repeat (2) @(posedge clk);
        $display("checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the timer subsystem testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --top-module reflet_timer_tb -f build.f -Mdir "$build_dir" -o reflet_timer_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/reflet_timer_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log_file"; then
    exit 0
fi
echo "pass line not found in $log_file"
exit 1

// ==== source/reflet_counter.sv ====
module reflet_counter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               clear,
    input  logic                               enable,
    input  logic [reflet_pkg::count_width-1:0] max,
    output logic                               out
);

    import reflet_pkg::*;

    logic [count_width-1:0] count;
    logic [count_width-1:0] last_count;
    logic                   at_last;

    // the count runs from zero up to max - 1 and then wraps.
    assign last_count = max - count_width'(1);
    assign at_last    = (count == last_count);

    // out only fires on an enabled cycle, which lets counters chain.
    assign out = enable && at_last;

    // ########################################
    // count register
    // ########################################

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (enable) begin
            if (at_last) begin
                count <= '0; // wrap after the last state.
            end else begin
                count <= count + count_width'(1);
            end
        end
    end

endmodule

// ==== source/reflet_interrupt_ctrl.sv ====
module reflet_interrupt_ctrl #(
    parameter logic [reflet_pkg::addr_width-1:0] base_addr = reflet_pkg::intc_base
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic [reflet_pkg::addr_width-1:0] addr,
    input  logic                              write_en,
    input  logic [reflet_pkg::data_width-1:0] data_in,
    output logic [reflet_pkg::data_width-1:0] data_out,
    input  logic [reflet_pkg::num_irq-1:0]    irq_pulse,
    output logic                              irq
);

    import reflet_pkg::*;

    localparam logic [addr_width-1:0] last_addr = base_addr + addr_width'(block_span - 1);

    // ########################################
    // address decode
    // ########################################

    logic                  selected;
    logic                  write_hit;
    logic [addr_width-1:0] rel_addr;
    intc_reg_e             offset;

    assign selected  = enable && (addr >= base_addr) && (addr <= last_addr);
    assign write_hit = selected && write_en;
    assign rel_addr  = addr - base_addr;
    assign offset    = intc_reg_e'(rel_addr[1:0]);

    // ########################################
    // pending and mask registers
    // ########################################

    logic [num_irq-1:0] pending;
    logic [num_irq-1:0] mask;
    logic [num_irq-1:0] clear_bits;

    // writing ones to the pending register clears those bits.
    assign clear_bits = (write_hit && offset == reg_pending) ? data_in[num_irq-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            // a pulse in the same cycle as the clear keeps the bit set.
            pending <= (pending & ~clear_bits) | irq_pulse;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mask <= '0;
        end else if (write_hit && offset == reg_mask) begin
            mask <= data_in[num_irq-1:0];
        end
    end

    // ########################################
    // read data and interrupt line
    // ########################################

    always_comb begin
        data_out = '0; // upper bits and unused offsets read zero.
        if (selected) begin
            case (offset)
                reg_pending: data_out = data_width'(pending);
                reg_mask:    data_out = data_width'(mask);
                default:     data_out = '0;
            endcase
        end
    end

    // level interrupt to the processor.
    assign irq = |(pending & mask);

endmodule

// ==== source/reflet_pkg.sv ====
package reflet_pkg;

    // ########################################
    // system bus
    // ########################################

    localparam int unsigned addr_width = 16;
    localparam int unsigned data_width = 8;

    // ########################################
    // address map
    // ########################################

    localparam logic [addr_width-1:0] timer0_base = 16'hFF10;
    localparam logic [addr_width-1:0] timer1_base = 16'hFF14;
    localparam logic [addr_width-1:0] intc_base   = 16'hFF18;

    // each block decodes four bytes. The last offset is left unused.
    localparam int unsigned block_span = 4;

    // ########################################
    // timer and interrupt sizing
    // ########################################

    // one bit wider than the data so that a prescaler of 255 + 1 still fits.
    localparam int unsigned count_width = 9;

    localparam int unsigned num_irq = 2; // one source per timer.

    // register offsets inside a timer window.
    typedef enum logic [1:0] {
        reg_pre1 = 2'd0,
        reg_pre2 = 2'd1,
        reg_arr  = 2'd2
    } timer_reg_e;

    // register offsets inside the interrupt controller window.
    typedef enum logic [1:0] {
        reg_pending = 2'd0,
        reg_mask    = 2'd1
    } intc_reg_e;

endpackage

// ==== source/reflet_timer.sv ====
module reflet_timer #(
    parameter logic [reflet_pkg::addr_width-1:0] base_addr = reflet_pkg::timer0_base
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic [reflet_pkg::addr_width-1:0] addr,
    input  logic                              write_en,
    input  logic [reflet_pkg::data_width-1:0] data_in,
    output logic [reflet_pkg::data_width-1:0] data_out,
    output logic                              interrupt
);

    import reflet_pkg::*;

    localparam logic [addr_width-1:0] last_addr = base_addr + addr_width'(block_span - 1);

    // ########################################
    // address decode
    // ########################################

    logic                  selected;
    logic                  write_hit;
    logic [addr_width-1:0] rel_addr;
    timer_reg_e            offset;

    assign selected  = enable && (addr >= base_addr) && (addr <= last_addr);
    assign write_hit = selected && write_en;
    assign rel_addr  = addr - base_addr;
    assign offset    = timer_reg_e'(rel_addr[1:0]); // only the low bits matter inside the window.

    // ########################################
    // configuration registers
    // ########################################

    logic [data_width-1:0] pre1;
    logic [data_width-1:0] pre2;
    logic [data_width-1:0] arr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pre1 <= '0;
            pre2 <= '0;
            arr  <= '0;
        end else if (write_hit) begin
            case (offset)
                reg_pre1: pre1 <= data_in;
                reg_pre2: pre2 <= data_in;
                reg_arr:  arr  <= data_in;
                default:  ; // offset 3 has no storage.
            endcase
        end
    end

    // read back is combinational and zero outside the window.
    always_comb begin
        data_out = '0;
        if (selected) begin
            case (offset)
                reg_pre1: data_out = pre1;
                reg_pre2: data_out = pre2;
                reg_arr:  data_out = arr;
                default:  data_out = '0;
            endcase
        end
    end

    // ########################################
    // configuration check
    // ########################################

    logic                   timer_active;
    logic                   chain_clear;
    logic [count_width-1:0] pre1_max;
    logic [count_width-1:0] pre2_max;
    logic [count_width-1:0] arr_max;

    // a zero reload or a full prescaler would never give a sane period.
    assign timer_active = (arr != '0) && (pre1 != '1) && (pre2 != '1);

    // any write restarts the chain so the phase is known after reconfiguration.
    assign chain_clear = !timer_active || write_hit;

    assign pre1_max = count_width'(pre1) + count_width'(1);
    assign pre2_max = count_width'(pre2) + count_width'(1);
    assign arr_max  = count_width'(arr);

    // ########################################
    // counter chain
    // ########################################

    logic pre1_out;
    logic pre2_out;

    reflet_counter pre1_cnt (
        .clk    (clk),
        .reset  (reset),
        .clear  (chain_clear),
        .enable (timer_active),
        .max    (pre1_max),
        .out    (pre1_out)
    );

    reflet_counter pre2_cnt (
        .clk    (clk),
        .reset  (reset),
        .clear  (chain_clear),
        .enable (pre1_out),
        .max    (pre2_max),
        .out    (pre2_out)
    );

    // the last stage pulses once per full period.
    reflet_counter arr_cnt (
        .clk    (clk),
        .reset  (reset),
        .clear  (chain_clear),
        .enable (pre2_out),
        .max    (arr_max),
        .out    (interrupt)
    );

endmodule

// ==== source/reflet_timer_subsystem.sv ====
module reflet_timer_subsystem (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic [reflet_pkg::addr_width-1:0] addr,
    input  logic                              write_en,
    input  logic [reflet_pkg::data_width-1:0] data_in,
    output logic [reflet_pkg::data_width-1:0] data_out,
    output logic                              irq
);

    import reflet_pkg::*;

    logic [data_width-1:0] timer0_data;
    logic [data_width-1:0] timer1_data;
    logic [data_width-1:0] intc_data;
    logic [num_irq-1:0]    timer_irq; // bit n comes from timer n.

    // ########################################
    // timers
    // ########################################

    reflet_timer #(
        .base_addr (timer0_base)
    ) timer0 (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (timer0_data),
        .interrupt (timer_irq[0])
    );

    reflet_timer #(
        .base_addr (timer1_base)
    ) timer1 (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (timer1_data),
        .interrupt (timer_irq[1])
    );

    // ########################################
    // interrupt controller
    // ########################################

    reflet_interrupt_ctrl #(
        .base_addr (intc_base)
    ) intc (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (intc_data),
        .irq_pulse (timer_irq),
        .irq       (irq)
    );

    // only the selected block drives nonzero data, so a plain OR merges them.
    assign data_out = timer0_data | timer1_data | intc_data;

endmodule
